/* Makefile */
VERILATOR ?= verilator
TOP       ?= rvCore_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= TEST PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* aluUnit.sv */
`include "rv_consts.svh"
`default_nettype none

module aluUnit import rv_pkg::*;
(
    input  aluOp_e           op,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    output logic [`XLEN-1:0] result
);

    logic [5:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = b[5:0];
    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb
    begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            SRA:     result = $signed(a) >>> shamt;
            SLT:     result = {{(`XLEN-1){1'b0}}, lessSigned};
            SLTU:    result = {{(`XLEN-1){1'b0}}, lessUnsigned};
            PASS_B:  result = b;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* immGen.sv */
`include "rv_consts.svh"
`default_nettype none

module immGen import rv_pkg::*;
(
    input  logic [31:0]      inst,
    output logic [`XLEN-1:0] imm
);

    opcode_e opcode;

    assign opcode = opcode_e'(inst[6:0]);

    always_comb
    begin
        case (opcode)
            OP_IMM, JALR, LOAD, SYSTEM:
            begin
                imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
            end
            STORE:
            begin
                imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            end
            LUI, AUIPC:
            begin
                imm = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            end
            JAL:
            begin
                imm = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default:
            begin
                imm = '0;   // r-type has no immediate
            end
        endcase
    end

endmodule

`default_nettype wire

/* loadStoreUnit.sv */
`include "rv_consts.svh"
`default_nettype none

module loadStoreUnit import rv_pkg::*;
(
    input  ctrl_t            ctrl,
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] storeData,
    input  logic [`XLEN-1:0] dataRdata,
    output dataReq_t         dataReq,
    output logic [`XLEN-1:0] loadData
);

    logic [2:0]       offset;
    logic [7:0]       sizeMask;
    logic [`XLEN-1:0] shifted;

    assign offset  = addr[2:0];
    assign shifted = dataRdata >> {offset, 3'b000};  // move lane down to byte 0

    always_comb
    begin
        case (ctrl.memSize)
            2'd0:    sizeMask = 8'h01;
            2'd1:    sizeMask = 8'h03;
            2'd2:    sizeMask = 8'h0f;
            default: sizeMask = 8'hff;
        endcase
    end

    always_comb
    begin
        dataReq.addr  = {addr[`XLEN-1:3], 3'b000};
        dataReq.wdata = storeData << {offset, 3'b000};
        dataReq.wstrb = ctrl.memWrite ? sizeMask << offset : 8'h00;
        dataReq.read  = ctrl.memRead;
        dataReq.write = ctrl.memWrite;
    end

    // extend from the access width
    always_comb
    begin
        case (ctrl.memSize)
            2'd0:
            begin
                loadData = {{(`XLEN-8){~ctrl.memUnsigned & shifted[7]}}, shifted[7:0]};
            end
            2'd1:
            begin
                loadData = {{(`XLEN-16){~ctrl.memUnsigned & shifted[15]}}, shifted[15:0]};
            end
            2'd2:
            begin
                loadData = {{(`XLEN-32){~ctrl.memUnsigned & shifted[31]}}, shifted[31:0]};
            end
            default:
            begin
                loadData = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

/* regFile.sv */
`include "rv_consts.svh"
`default_nettype none

module regFile
(
    input  logic             clk,
    input  logic             rstN,
    input  logic             we,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       rd,
    input  logic [`XLEN-1:0] wdata,
    output logic [`XLEN-1:0] rdata1,
    output logic [`XLEN-1:0] rdata2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && rd != 5'd0)  // x0 never written
        begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

/* rvCore.sv */
`include "rv_consts.svh"
`default_nettype none

module rvCore import rv_pkg::*;
(
    input  logic             clk,
    input  logic             rstN,
    input  logic [31:0]      inst,
    input  logic [`XLEN-1:0] dataRdata,
    output logic [`XLEN-1:0] instAddr,
    output dataReq_t         dataReq,
    output logic             halted
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pcNext;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] loadData;
    logic [`XLEN-1:0] wbData;
    ctrl_t            ctrl;
    ctrl_t            ctrlGated;

    rvDecoder uDecoder (.inst(inst), .ctrl(ctrl));

    immGen uImmGen (.inst(inst), .imm(imm));

    regFile uRegFile
    (
        .clk    (clk),
        .rstN   (rstN),
        .we     (ctrlGated.writeRd),
        .rs1    (inst[19:15]),
        .rs2    (inst[24:20]),
        .rd     (inst[11:7]),
        .wdata  (wbData),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    aluUnit uAlu (.op(ctrl.aluOp), .a(opA), .b(opB), .result(aluResult));

    loadStoreUnit uLsu
    (
        .ctrl      (ctrlGated),
        .addr      (aluResult),
        .storeData (rdata2),
        .dataRdata (dataRdata),
        .dataReq   (dataReq),
        .loadData  (loadData)
    );

    // no side effects once halted
    always_comb
    begin
        ctrlGated = ctrl;
        if (halted)
        begin
            ctrlGated.writeRd  = 1'b0;
            ctrlGated.memRead  = 1'b0;
            ctrlGated.memWrite = 1'b0;
        end
    end

    assign instAddr = pc;
    assign pcPlus4  = pc + `XLEN'd4;
    assign opA      = ctrl.selA ? pc : rdata1;
    assign opB      = ctrl.selB ? imm : rdata2;

    always_comb
    begin
        case (ctrl.wbSel)
            MEM:     wbData = loadData;
            PC4:     wbData = pcPlus4;  // link
            default: wbData = aluResult;
        endcase
    end

    always_comb
    begin
        if (halted || ctrl.isEbreak)
            pcNext = pc;                // park on the ebreak
        else if (ctrl.jumpReg)
            pcNext = {aluResult[`XLEN-1:1], 1'b0};
        else if (ctrl.jump)
            pcNext = pc + imm;
        else
            pcNext = pcPlus4;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pc     <= `RESET_PC;
            halted <= 1'b0;
        end
        else
        begin
            pc <= pcNext;
            if (ctrl.isEbreak)
            begin
                halted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rvCore_assertions.sv */
`include "rv_consts.svh"
`default_nettype none

module rvCore_assertions import rv_pkg::*;
(
    input logic             clk,
    input logic             rstN,
    input logic [`XLEN-1:0] instAddr,
    input dataReq_t         dataReq,
    input logic             halted
);
    timeunit 1ns;
    timeprecision 100ps;

    readWriteExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(dataReq.read && dataReq.write))
    else $error("data port asked for read and write in one cycle");

    strobeNeedsWrite: assert property (@(posedge clk) disable iff (!rstN)
        !dataReq.write |-> dataReq.wstrb == 8'h00)
    else $error("byte strobes set without a write");

    haltedQuiet: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !dataReq.read && !dataReq.write && dataReq.wstrb == 8'h00)
    else $error("data request while halted");

    haltedPcFrozen: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> $stable(instAddr))
    else $error("instruction address moved while halted");

endmodule

bind rvCore rvCore_assertions uAssertions
(
    .clk      (clk),
    .rstN     (rstN),
    .instAddr (instAddr),
    .dataReq  (dataReq),
    .halted   (halted)
);

`default_nettype wire

/* rvCore_tb.sv */
`include "rv_consts.svh"
`default_nettype none

module rvCore_tb import rv_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int imemWords  = 256;
    localparam int dmemBytes  = 512;    // mapped at 0x1000, x1 holds the base
    localparam int dmemBase   = 'h1000;
    localparam int opndOff    = 'h100;
    localparam int loadOff    = 'h180;
    localparam int progCycles = 42 + 10 + 20 + 15 + 8;
    localparam int waitCycles = 5 * 8 + 4;
    localparam int watchdogNs = (progCycles + waitCycles) * 40 + 2000;

    logic             clk;
    logic             rstN;
    logic [31:0]      inst;
    logic [`XLEN-1:0] dataRdata;
    logic [`XLEN-1:0] instAddr;
    dataReq_t         dataReq;
    logic             halted;

    logic [31:0]      imem [imemWords];
    logic [7:0]       dmem [dmemBytes];
    dataReq_t         storeLog [$];
    logic [`XLEN-1:0] instOff;
    int               progLen;
    int               seed = 68;

    rvCore DUT
    (
        .clk       (clk),
        .rstN      (rstN),
        .inst      (inst),
        .dataRdata (dataRdata),
        .instAddr  (instAddr),
        .dataReq   (dataReq),
        .halted    (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign instOff = instAddr - `RESET_PC;
    assign inst    = imem[instOff[9:2]];

    always_comb
    begin
        dataRdata = '0;     // idle bus unless reading
        if (dataReq.read)
        begin
            for (int k = 0; k < 8; k++)
            begin
                dataRdata[8*k +: 8] = dmem[{dataReq.addr[8:3], 3'(k)}];
            end
        end
    end

    always @(posedge clk)
    begin
        if (rstN && (dataReq.read || dataReq.write))
            checkTrue((dataReq.addr & ~64'h1f8) == 64'(dmemBase),
                      "data access outside the data memory or not 8-byte aligned");
        if (rstN && dataReq.write && dataReq.wstrb != 8'h00)
        begin
            for (int k = 0; k < 8; k++)
            begin
                if (dataReq.wstrb[k])
                    dmem[{dataReq.addr[8:3], 3'(k)}] <= dataReq.wdata[8*k +: 8];
            end
            storeLog.push_back(dataReq);
        end
    end

    initial
    begin
        #(watchdogNs);
        reportFailure("timeout: the core did not reach ebreak in time");
    end

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkEq(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        assert (actual === expected)
        else reportFailure($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic checkTrue(input logic cond, input string what);
        assert (cond === 1'b1)
        else reportFailure(what);
    endtask

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    function automatic logic [2:0] f3For(input aluOp_e op);
        case (op)
            SLL:      return 3'b001;
            SLT:      return 3'b010;
            SLTU:     return 3'b011;
            XOR:      return 3'b100;
            SRL, SRA: return 3'b101;
            OR:       return 3'b110;
            AND:      return 3'b111;
            default:  return 3'b000;    // add, sub
        endcase
    endfunction

    function automatic logic [6:0] altOf(input aluOp_e op);
        return (op == SUB || op == SRA) ? `F7_ALT : 7'b0;
    endfunction

    // expected results straight from the ISA definitions
    function automatic logic [63:0] aluRef(input aluOp_e op, input logic [63:0] a,
                                           input logic [63:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[5:0];
            SRL:     return a >> b[5:0];
            SRA:     return $signed(a) >>> b[5:0];
            SLT:     return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            SLTU:    return (a < b) ? 64'd1 : 64'd0;
            default: return b;
        endcase
    endfunction

    function automatic logic [63:0] loadRef(input logic [63:0] word, input logic [2:0] f3,
                                            input int off);
        logic [63:0] s;
        s = word >> (8 * off);
        case (f3)
            `F3_B:   return {{56{s[7]}}, s[7:0]};
            `F3_BU:  return {56'h0, s[7:0]};
            `F3_H:   return {{48{s[15]}}, s[15:0]};
            `F3_HU:  return {48'h0, s[15:0]};
            `F3_W:   return {{32{s[31]}}, s[31:0]};
            `F3_WU:  return {32'h0, s[31:0]};
            default: return s;
        endcase
    endfunction

    function automatic logic [7:0] patternByte(input int addr);
        return 8'((addr * 13) ^ (addr >> 8) ^ 'hA5);
    endfunction

    function automatic logic [63:0] getMem64(input int off);
        logic [63:0] v;
        for (int k = 0; k < 8; k++)
            v[8*k +: 8] = dmem[off + k];
        return v;
    endfunction

    task automatic putMem64(input int off, input logic [63:0] v);
        for (int k = 0; k < 8; k++)
            dmem[off + k] <= v[8*k +: 8];
    endtask

    task automatic fillMemories;
        for (int i = 0; i < imemWords; i++)
            imem[i] = encI(12'(i), 5'd0, 3'b000, 5'd0, `OPC_OP_IMM);  // addi x0, x0, i
        for (int i = 0; i < dmemBytes; i++)
            dmem[i] <= patternByte(i);
    endtask

    task automatic emit(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic beginTest;
        @(posedge clk);
        rstN <= 1'b0;
        progLen = 0;
        fillMemories();
        storeLog.delete();
        emit(encU(20'h00001, 5'd1, `OPC_LUI));     // x1 = data base
    endtask

    task automatic runProgram;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        do
        begin
            @(negedge clk);
        end
        while (!halted);
    endtask

    task automatic testAlu;
        aluOp_e      rOps [10] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU};
        aluOp_e      iOps [9]  = '{ADD, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA};
        logic [11:0] imms [9];
        logic [63:0] a;
        logic [63:0] b;
        a = {$random(seed), $random(seed)};
        b = {$random(seed), $random(seed)};
        beginTest();
        putMem64(opndOff, a);
        putMem64(opndOff + 8, b);
        emit(encI(12'(opndOff), 5'd1, `F3_D, 5'd2, `OPC_LOAD));
        emit(encI(12'(opndOff + 8), 5'd1, `F3_D, 5'd3, `OPC_LOAD));
        foreach (rOps[i])
        begin
            emit(encR(altOf(rOps[i]), 5'd3, 5'd2, f3For(rOps[i]), 5'd4));
            emit(encS(12'(8 * i), 5'd4, 5'd1, `F3_D));
        end
        foreach (iOps[i])
        begin
            imms[i] = 12'($random(seed));
            if (iOps[i] == SLL || iOps[i] == SRL || iOps[i] == SRA)
                imms[i] = {((iOps[i] == SRA) ? 6'b010000 : 6'b000000), imms[i][5:0]};
            emit(encI(imms[i], 5'd2, f3For(iOps[i]), 5'd4, `OPC_OP_IMM));
            emit(encS(12'(8 * (10 + i)), 5'd4, 5'd1, `F3_D));
        end
        emit(`INST_EBREAK);
        runProgram();
        foreach (rOps[i])
            checkEq($sformatf("alu %s", rOps[i].name()), aluRef(rOps[i], a, b),
                    getMem64(8 * i));
        foreach (iOps[i])
            checkEq($sformatf("alu imm %s", iOps[i].name()),
                    aluRef(iOps[i], a, {{52{imms[i][11]}}, imms[i]}),
                    getMem64(8 * (10 + i)));
    endtask

    task automatic testStoreWidths;
        logic [2:0]  widths [7] = '{`F3_B, `F3_H, `F3_W, `F3_D, `F3_B, `F3_H, `F3_W};
        int          offs [7]   = '{3, 10, 20, 24, 39, 46, 48};
        logic [7:0]  expMem [dmemBytes];
        logic [63:0] v;
        v = {$random(seed), $random(seed)};
        beginTest();
        putMem64(opndOff, v);
        for (int i = 0; i < dmemBytes; i++)
            expMem[i] = patternByte(i);
        for (int k = 0; k < 8; k++)
            expMem[opndOff + k] = v[8*k +: 8];
        emit(encI(12'(opndOff), 5'd1, `F3_D, 5'd2, `OPC_LOAD));
        foreach (widths[i])
        begin
            emit(encS(12'(offs[i]), 5'd2, 5'd1, widths[i]));
            for (int k = 0; k < (1 << widths[i][1:0]); k++)
                expMem[offs[i] + k] = v[8*k +: 8];  // little endian
        end
        emit(`INST_EBREAK);
        runProgram();
        checkEq("store widths count", 64'd7, 64'(storeLog.size()));
        for (int i = 0; i < dmemBytes; i++)
            checkEq($sformatf("store widths byte 0x%0h", i), 64'(expMem[i]), 64'(dmem[i]));
    endtask

    task automatic testLoadExtension;
        logic [2:0]  widths [8] = '{`F3_B, `F3_BU, `F3_B, `F3_H, `F3_HU, `F3_W, `F3_WU, `F3_D};
        int          offs [8]   = '{1, 1, 0, 2, 6, 0, 4, 0};
        logic [63:0] v;
        v = {$random(seed), $random(seed)};
        v = (v | 64'h8000_8000_8000_8000) & ~64'h80;   // negative lanes, byte 0 positive
        beginTest();
        putMem64(opndOff, v);
        emit(encI(12'(opndOff), 5'd1, `F3_D, 5'd2, `OPC_LOAD));
        emit(encS(12'(loadOff), 5'd2, 5'd1, `F3_D));
        foreach (widths[i])
        begin
            emit(encI(12'(loadOff + offs[i]), 5'd1, widths[i], 5'd4, `OPC_LOAD));
            emit(encS(12'(8 * i), 5'd4, 5'd1, `F3_D));
        end
        emit(`INST_EBREAK);
        runProgram();
        foreach (widths[i])
            checkEq($sformatf("load funct3 %0d offset %0d", widths[i], offs[i]),
                    loadRef(v, widths[i], offs[i]), getMem64(8 * i));
    endtask

    task automatic testJumps;
        logic [19:0] luiImm   = 20'hABCDE;
        logic [19:0] auipcImm = 20'h12345;
        beginTest();
        emit(encU(luiImm, 5'd5, `OPC_LUI));
        emit(encS(12'd0, 5'd5, 5'd1, `F3_D));
        emit(encU(auipcImm, 5'd6, `OPC_AUIPC));            // pc + 12
        emit(encS(12'd8, 5'd6, 5'd1, `F3_D));
        emit(encJ(21'd12, 5'd7));                            // pc + 20 to pc + 32
        emit(encS(12'h040, 5'd0, 5'd1, `F3_D));
        emit(encS(12'h048, 5'd0, 5'd1, `F3_D));
        emit(encS(12'd16, 5'd7, 5'd1, `F3_D));
        emit(encU(20'h00000, 5'd8, `OPC_AUIPC));            // x8 = pc + 36
        emit(encI(12'd17, 5'd8, 3'b000, 5'd9, `OPC_JALR));  // odd target
        emit(encS(12'h050, 5'd0, 5'd1, `F3_D));
        emit(encS(12'h058, 5'd0, 5'd1, `F3_D));
        emit(encS(12'd24, 5'd9, 5'd1, `F3_D));
        emit(`INST_EBREAK);
        runProgram();
        checkEq("lui", {{32{luiImm[19]}}, luiImm, 12'h000}, getMem64(0));
        checkEq("auipc", `RESET_PC + 12 + {{32{auipcImm[19]}}, auipcImm, 12'h000},
                getMem64(8));
        checkEq("jal link", `RESET_PC + 24, getMem64(16));
        checkEq("jalr link", `RESET_PC + 44, getMem64(24));
        checkEq("jump store count", 64'd4, 64'(storeLog.size()));
    endtask

    task automatic testHalt;
        logic [63:0] v;
        logic [63:0] haltAddr;
        v = {$random(seed), $random(seed)} | 64'h1;
        haltAddr = `RESET_PC + 24;
        beginTest();
        putMem64(opndOff, v);
        emit(encI(12'h055, 5'd0, 3'b000, 5'd0, `OPC_OP_IMM));
        emit(encI(12'(opndOff), 5'd1, `F3_D, 5'd0, `OPC_LOAD));
        emit(encS(12'd0, 5'd0, 5'd1, `F3_D));
        emit(encI(12'd7, 5'd0, 3'b000, 5'd3, `OPC_OP_IMM));
        emit(encS(12'd8, 5'd3, 5'd1, `F3_D));
        emit(`INST_EBREAK);
        emit(encS(12'd16, 5'd3, 5'd1, `F3_D));                // never runs
        runProgram();
        checkEq("x0 stays zero", 64'd0, getMem64(0));
        checkEq("x0 as source", 64'd7, getMem64(8));
        imem[6] = encS(12'd16, 5'd3, 5'd1, `F3_D);          // store under the parked pc
        repeat (4)
        begin
            checkEq("halt pc", haltAddr, instAddr);
            checkTrue(halted, "halted dropped after ebreak without a reset");
            @(negedge clk);
        end
        checkEq("stores after halt", 64'd2, 64'(storeLog.size()));
    endtask

    initial
    begin
        rstN = 1'b0;
        progLen = 0;
        fillMemories();
        testAlu();
        testStoreWidths();
        testLoadExtension();
        testJumps();
        testHalt();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* rvDecoder.sv */
`include "rv_consts.svh"
`default_nettype none

module rvDecoder import rv_pkg::*;
(
    input  logic [31:0] inst,
    output ctrl_t       ctrl
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;
    logic       opValid;
    logic       immValid;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign funct6 = inst[31:26];    // rv64 shamt is 6 bits

    // funct7 only allowed to be alt on add/sub and srl/sra
    assign opValid = (funct7 == 7'b0) ||
                     (funct7 == `F7_ALT && (funct3 == `F3_ADD || funct3 == `F3_SR));

    always_comb
    begin
        case (funct3)
            `F3_SL:  immValid = (funct6 == 6'b0);
            `F3_SR:  immValid = (funct6 == 6'b0) || (funct6 == `F7_ALT >> 1);
            default: immValid = 1'b1;
        endcase
    end

    function automatic aluOp_e aluFromF3(input logic [2:0] f3, input logic alt);
        aluOp_e op;
        case (f3)
            3'b000:  op = alt ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    always_comb
    begin
        ctrl       = '0;            // nop unless decoded below
        ctrl.aluOp = ADD;
        ctrl.wbSel = ALU;
        case (opcode)
            OP:
            begin
                if (opValid)
                begin
                    ctrl.aluOp   = aluFromF3(funct3, inst[30]);
                    ctrl.writeRd = 1'b1;
                end
            end
            OP_IMM:
            begin
                if (immValid)
                begin
                    ctrl.aluOp   = aluFromF3(funct3, funct3 == `F3_SR && inst[30]);
                    ctrl.selB    = 1'b1;
                    ctrl.writeRd = 1'b1;
                end
            end
            LUI:
            begin
                ctrl.aluOp   = PASS_B;
                ctrl.selB    = 1'b1;
                ctrl.writeRd = 1'b1;
            end
            AUIPC:
            begin
                ctrl.selA    = 1'b1;
                ctrl.selB    = 1'b1;
                ctrl.writeRd = 1'b1;
            end
            JAL:
            begin
                ctrl.writeRd = 1'b1;
                ctrl.wbSel   = PC4;
                ctrl.jump    = 1'b1;
            end
            JALR:
            begin
                if (funct3 == 3'b000)
                begin
                    ctrl.selB    = 1'b1;
                    ctrl.writeRd = 1'b1;
                    ctrl.wbSel   = PC4;
                    ctrl.jump    = 1'b1;
                    ctrl.jumpReg = 1'b1;
                end
            end
            LOAD:
            begin
                case (funct3)
                    `F3_B, `F3_H, `F3_W, `F3_D, `F3_BU, `F3_HU, `F3_WU:
                    begin
                        ctrl.selB        = 1'b1;
                        ctrl.writeRd     = 1'b1;
                        ctrl.wbSel       = MEM;
                        ctrl.memRead     = 1'b1;
                        ctrl.memSize     = funct3[1:0];
                        ctrl.memUnsigned = funct3[2];
                    end
                    default: ;
                endcase
            end
            STORE:
            begin
                case (funct3)
                    `F3_B, `F3_H, `F3_W, `F3_D:
                    begin
                        ctrl.selB     = 1'b1;   // address is rs1 + imm
                        ctrl.memWrite = 1'b1;
                        ctrl.memSize  = funct3[1:0];
                    end
                    default: ;
                endcase
            end
            SYSTEM:
            begin
                ctrl.isEbreak = (inst == `INST_EBREAK);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH
`default_nettype none

`define XLEN        64
`define REG_COUNT   32
`define RESET_PC    64'h0000_0000_8000_0000

// major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_SYSTEM  7'b1110011

`define F3_B        3'b000
`define F3_H        3'b001
`define F3_W        3'b010
`define F3_D        3'b011
`define F3_BU       3'b100
`define F3_HU       3'b101
`define F3_WU       3'b110

`define F3_ADD      3'b000      // add/sub
`define F3_SL       3'b001      // shift left
`define F3_SR       3'b101      // shift right, logic or arith
`define F7_ALT      7'b0100000  // sub / sra
`define INST_EBREAK 32'h0010_0073

`default_nettype wire
`endif

/* rv_pkg.sv */
`include "rv_consts.svh"
`default_nettype none

package rv_pkg;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA,
        SLT, SLTU,
        PASS_B              // lui
    } aluOp_e;

    typedef enum logic [6:0] {
        OP     = `OPC_OP,
        OP_IMM = `OPC_OP_IMM,
        LUI    = `OPC_LUI,
        AUIPC  = `OPC_AUIPC,
        JAL    = `OPC_JAL,
        JALR   = `OPC_JALR,
        LOAD   = `OPC_LOAD,
        STORE  = `OPC_STORE,
        SYSTEM = `OPC_SYSTEM
    } opcode_e;

    typedef enum logic [1:0] {
        ALU, MEM, PC4
    } wbSel_e;

    typedef struct packed {
        aluOp_e     aluOp;
        logic       selA;           // 1: pc
        logic       selB;           // 1: imm
        logic       writeRd;
        wbSel_e     wbSel;
        logic       memRead;
        logic       memWrite;
        logic [1:0] memSize;        // log2 of bytes
        logic       memUnsigned;
        logic       jump;
        logic       jumpReg;        // jalr target from alu
        logic       isEbreak;
    } ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0] addr;     // 8-byte aligned
        logic [`XLEN-1:0] wdata;
        logic [7:0]       wstrb;
        logic             read;
        logic             write;
    } dataReq_t;

endpackage

`default_nettype wire

/* tb.f */
+incdir+.
rv_pkg.sv
rvDecoder.sv
immGen.sv
aluUnit.sv
regFile.sv
loadStoreUnit.sv
rvCore.sv
rvCore_assertions.sv
rvCore_tb.sv
